// ==== hdl/tnoc_cfg.svh ====
`ifndef TNOC_CFG_SVH
`define TNOC_CFG_SVH

// address width shared by the AXI4-Lite side and the request flit.
`define TNOC_ADDR_W 16

// data width of AXI4-Lite write data, read data and flit payload.
`define TNOC_DATA_W 32

// number of virtual channels on the network output link.
`define TNOC_VCS 2

// width of a virtual channel index, enough to count TNOC_VCS channels.
`define TNOC_VC_W 1

`endif

// ==== hdl/tnoc_pkg.sv ====
`include "tnoc_cfg.svh"

package tnoc_pkg;

  typedef logic [`TNOC_ADDR_W-1:0] tnoc_addr_t;
  typedef logic [`TNOC_DATA_W-1:0] tnoc_data_t;
  typedef logic [3:0]              tnoc_strb_t;
  typedef logic [`TNOC_VC_W-1:0]   tnoc_vc_t;
  typedef logic [0:0]              tnoc_kind_t;
  typedef logic [1:0]              tnoc_resp_t;

  localparam tnoc_kind_t TNOC_KIND_WRITE = 1'b0;
  localparam tnoc_kind_t TNOC_KIND_READ  = 1'b1;
  localparam tnoc_resp_t TNOC_RESP_OKAY  = 2'b00;

  // single-flit request, the vc field is filled in by the write/read mux.
  typedef struct packed {
    tnoc_kind_t kind;
    tnoc_vc_t   vc;
    tnoc_addr_t addr;
    tnoc_data_t data;
    tnoc_strb_t strb;
  } tnoc_flit_t;

  typedef struct packed {
    tnoc_data_t data;
    tnoc_resp_t resp;
  } tnoc_rsp_t;

  typedef struct packed {
    tnoc_addr_t addr;
    logic [2:0] prot;
  } tnoc_axil_a_t;

  typedef struct packed {
    tnoc_data_t data;
    tnoc_strb_t strb;
  } tnoc_axil_w_t;

  typedef struct packed {
    tnoc_data_t data;
    tnoc_resp_t resp;
  } tnoc_axil_r_t;

  typedef enum logic [1:0] {WR_COLLECT, WR_SEND, WR_RESP} tnoc_wr_state_e;

  typedef enum logic [1:0] {RD_IDLE, RD_SEND, RD_WAIT, RD_RESP} tnoc_rd_state_e;

endpackage

// ==== hdl/tnoc_axi_write_packetizer.sv ====
`timescale 1ns/1ns

module tnoc_axi_write_packetizer
  import tnoc_pkg::*;
(
  input  logic           clk,
  input  logic           i_rst_n,
  input  logic           i_aw_valid,
  input  tnoc_axil_a_t   i_aw,
  output logic           o_aw_ready,
  input  logic           i_w_valid,
  input  tnoc_axil_w_t   i_w,
  output logic           o_w_ready,
  output logic           o_b_valid,
  output tnoc_resp_t     o_b_resp,
  input  logic           i_b_ready,
  output logic           o_flit_valid,
  output tnoc_flit_t     o_flit,
  input  logic           i_flit_ready
);

  tnoc_wr_state_e state;
  logic           aw_held;
  logic           w_held;
  logic           aw_fire;
  logic           w_fire;
  logic           both_held;
  tnoc_addr_t     addr_q;
  tnoc_data_t     data_q;
  tnoc_strb_t     strb_q;

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // AW and W collection
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // each half is accepted once, in whatever order the master sends it.
  assign o_aw_ready = (state == WR_COLLECT) && !aw_held;
  assign o_w_ready  = (state == WR_COLLECT) && !w_held;
  assign aw_fire    = i_aw_valid && o_aw_ready;
  assign w_fire     = i_w_valid && o_w_ready;
  assign both_held  = (aw_held || aw_fire) && (w_held || w_fire);

  always_ff @(posedge clk) begin
    if (aw_fire) begin
      addr_q <= i_aw.addr;
    end
    if (w_fire) begin
      data_q <= i_w.data;
      strb_q <= i_w.strb;
    end
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      state   <= WR_COLLECT;
      aw_held <= 1'b0;
      w_held  <= 1'b0;
    end else begin
      case (state)
        WR_COLLECT: begin
          if (both_held) begin
            state   <= WR_SEND;
            aw_held <= 1'b0;
            w_held  <= 1'b0;
          end else begin
            aw_held <= aw_held || aw_fire;
            w_held  <= w_held || w_fire;
          end
        end
        WR_SEND: begin
          if (i_flit_ready) begin
            state <= WR_RESP;
          end
        end
        WR_RESP: begin
          if (i_b_ready) begin
            state <= WR_COLLECT;
          end
        end
        default: state <= WR_COLLECT;
      endcase
    end
  end

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // flit and B response
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    o_flit      = '0;
    o_flit.kind = TNOC_KIND_WRITE;
    o_flit.addr = addr_q;
    o_flit.data = data_q;
    o_flit.strb = strb_q;
  end

  assign o_flit_valid = (state == WR_SEND);

  // the write is reported done only once the network has taken its flit.
  assign o_b_valid = (state == WR_RESP);
  assign o_b_resp  = TNOC_RESP_OKAY;

endmodule

// ==== hdl/tnoc_axi_read_packetizer.sv ====
`timescale 1ns/1ns

module tnoc_axi_read_packetizer
  import tnoc_pkg::*;
(
  input  logic          clk,
  input  logic          i_rst_n,
  input  logic          i_ar_valid,
  input  tnoc_axil_a_t  i_ar,
  output logic          o_ar_ready,
  output logic          o_flit_valid,
  output tnoc_flit_t    o_flit,
  input  logic          i_flit_ready,
  input  logic          i_rsp_valid,
  input  tnoc_rsp_t     i_rsp,
  output logic          o_rsp_ready,
  output logic          o_r_valid,
  output tnoc_axil_r_t  o_r,
  input  logic          i_r_ready
);

  tnoc_rd_state_e state;
  logic           ar_fire;
  logic           rsp_fire;
  tnoc_addr_t     addr_q;
  tnoc_axil_r_t   r_q;

  assign o_ar_ready  = (state == RD_IDLE);
  assign o_rsp_ready = (state == RD_WAIT);
  assign ar_fire     = i_ar_valid && o_ar_ready;
  assign rsp_fire    = i_rsp_valid && o_rsp_ready;

  always_ff @(posedge clk) begin
    if (ar_fire) begin
      addr_q <= i_ar.addr;
    end
    if (rsp_fire) begin
      r_q.data <= i_rsp.data;
      r_q.resp <= i_rsp.resp;
    end
  end

  // only one read is in flight, so responses need no tag.
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      state <= RD_IDLE;
    end else begin
      case (state)
        RD_IDLE: begin
          if (ar_fire) begin
            state <= RD_SEND;
          end
        end
        RD_SEND: begin
          if (i_flit_ready) begin
            state <= RD_WAIT;
          end
        end
        RD_WAIT: begin
          if (rsp_fire) begin
            state <= RD_RESP;
          end
        end
        RD_RESP: begin
          if (i_r_ready) begin
            state <= RD_IDLE;
          end
        end
        default: state <= RD_IDLE;
      endcase
    end
  end

  // read flits carry no data and no strobes.
  always_comb begin
    o_flit      = '0;
    o_flit.kind = TNOC_KIND_READ;
    o_flit.addr = addr_q;
  end

  assign o_flit_valid = (state == RD_SEND);
  assign o_r_valid    = (state == RD_RESP);
  assign o_r          = r_q;

endmodule

// ==== hdl/tnoc_axi_write_read_mux.sv ====
`timescale 1ns/1ns

`include "tnoc_cfg.svh"

module tnoc_axi_write_read_mux
  import tnoc_pkg::*;
(
  input  logic                 clk,
  input  logic                 i_rst_n,
  input  tnoc_vc_t             i_write_vc,
  input  logic                 i_write_valid,
  input  tnoc_flit_t           i_write_flit,
  output logic                 o_write_ready,
  input  tnoc_vc_t             i_read_vc,
  input  logic                 i_read_valid,
  input  tnoc_flit_t           i_read_flit,
  output logic                 o_read_ready,
  output logic                 o_flit_valid,
  output tnoc_flit_t           o_flit,
  input  logic [`TNOC_VCS-1:0] i_flit_vc_ready
);

  tnoc_flit_t write_flit;
  tnoc_flit_t read_flit;
  logic       write_eligible;
  logic       read_eligible;
  logic       grant_read;
  logic       flit_taken;
  logic       ptr_read_q;

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // VC stamping
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    write_flit    = i_write_flit;
    write_flit.vc = i_write_vc;
    read_flit     = i_read_flit;
    read_flit.vc  = i_read_vc;
  end

  // a source may only compete while its own VC can accept a flit.
  assign write_eligible = i_write_valid && i_flit_vc_ready[i_write_vc];
  assign read_eligible  = i_read_valid && i_flit_vc_ready[i_read_vc];

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // round-robin arbitration
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    if (write_eligible && read_eligible) begin
      grant_read = ptr_read_q;
    end else begin
      grant_read = read_eligible;
    end
  end

  // a flit is offered only on a cycle where its VC is ready, so every offer is taken at once.
  assign o_flit_valid = grant_read ? read_eligible : write_eligible;
  assign o_flit       = grant_read ? read_flit : write_flit;
  assign flit_taken   = o_flit_valid && i_flit_vc_ready[o_flit.vc];

  assign o_write_ready = !grant_read && i_flit_vc_ready[i_write_vc];
  assign o_read_ready  = grant_read && i_flit_vc_ready[i_read_vc];

  // the pointer turns to the other source after every flit that leaves.
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      ptr_read_q <= 1'b0;
    end else if (flit_taken) begin
      ptr_read_q <= !grant_read;
    end
  end

endmodule

// ==== hdl/tnoc_axi_local_port.sv ====
`timescale 1ns/1ns

`include "tnoc_cfg.svh"

module tnoc_axi_local_port
  import tnoc_pkg::*;
(
  input  logic                 clk,
  input  logic                 i_rst_n,
  input  logic                 i_aw_valid,
  input  tnoc_axil_a_t         i_aw,
  output logic                 o_aw_ready,
  input  logic                 i_w_valid,
  input  tnoc_axil_w_t         i_w,
  output logic                 o_w_ready,
  output logic                 o_b_valid,
  output tnoc_resp_t           o_b_resp,
  input  logic                 i_b_ready,
  input  logic                 i_ar_valid,
  input  tnoc_axil_a_t         i_ar,
  output logic                 o_ar_ready,
  output logic                 o_r_valid,
  output tnoc_axil_r_t         o_r,
  input  logic                 i_r_ready,
  output logic                 o_flit_valid,
  output tnoc_flit_t           o_flit,
  input  logic [`TNOC_VCS-1:0] i_flit_vc_ready,
  input  logic                 i_rsp_valid,
  input  tnoc_rsp_t            i_rsp,
  output logic                 o_rsp_ready,
  input  tnoc_vc_t             i_write_vc,
  input  tnoc_vc_t             i_read_vc
);

  logic       write_valid;
  tnoc_flit_t write_flit;
  logic       write_ready;
  logic       read_valid;
  tnoc_flit_t read_flit;
  logic       read_ready;

  tnoc_axi_write_packetizer u_write_packetizer (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_aw_valid   (i_aw_valid),
    .i_aw         (i_aw),
    .o_aw_ready   (o_aw_ready),
    .i_w_valid    (i_w_valid),
    .i_w          (i_w),
    .o_w_ready    (o_w_ready),
    .o_b_valid    (o_b_valid),
    .o_b_resp     (o_b_resp),
    .i_b_ready    (i_b_ready),
    .o_flit_valid (write_valid),
    .o_flit       (write_flit),
    .i_flit_ready (write_ready)
  );

  tnoc_axi_read_packetizer u_read_packetizer (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_ar_valid   (i_ar_valid),
    .i_ar         (i_ar),
    .o_ar_ready   (o_ar_ready),
    .o_flit_valid (read_valid),
    .o_flit       (read_flit),
    .i_flit_ready (read_ready),
    .i_rsp_valid  (i_rsp_valid),
    .i_rsp        (i_rsp),
    .o_rsp_ready  (o_rsp_ready),
    .o_r_valid    (o_r_valid),
    .o_r          (o_r),
    .i_r_ready    (i_r_ready)
  );

  tnoc_axi_write_read_mux u_write_read_mux (
    .clk             (clk),
    .i_rst_n         (i_rst_n),
    .i_write_vc      (i_write_vc),
    .i_write_valid   (write_valid),
    .i_write_flit    (write_flit),
    .o_write_ready   (write_ready),
    .i_read_vc       (i_read_vc),
    .i_read_valid    (read_valid),
    .i_read_flit     (read_flit),
    .o_read_ready    (read_ready),
    .o_flit_valid    (o_flit_valid),
    .o_flit          (o_flit),
    .i_flit_vc_ready (i_flit_vc_ready)
  );

endmodule

// ==== dv/tnoc_axi_local_port_assert.sv ====
`timescale 1ns/1ns

module tnoc_axi_local_port_assert
  import tnoc_pkg::*;
(
  input logic         clk,
  input logic         i_rst_n,
  input logic         i_write_valid,
  input tnoc_flit_t   i_write_flit,
  input logic         i_write_ready,
  input logic         i_read_valid,
  input tnoc_flit_t   i_read_flit,
  input logic         i_read_ready,
  input logic         o_b_valid,
  input logic         i_b_ready,
  input logic         o_r_valid,
  input tnoc_axil_r_t o_r,
  input logic         i_r_ready,
  input logic         i_rsp_valid,
  input tnoc_rsp_t    i_rsp,
  input logic         o_rsp_ready
);

  // a packetizer flit that the mux did not take must come back unchanged.
  write_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_write_valid && !i_write_ready |=> i_write_valid && $stable(i_write_flit))
    else $error("write flit dropped or changed before it was taken");

  read_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_read_valid && !i_read_ready |=> i_read_valid && $stable(i_read_flit))
    else $error("read flit dropped or changed before it was taken");

  b_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
    o_b_valid && !i_b_ready |=> o_b_valid)
    else $error("B response withdrawn before acceptance");

  r_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
    o_r_valid && !i_r_ready |=> o_r_valid && $stable(o_r))
    else $error("R response withdrawn or changed before acceptance");

  // a network response reaches R on the next cycle, and no second one is taken meanwhile.
  rsp_to_r: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_rsp_valid && o_rsp_ready |=> o_r_valid && !o_rsp_ready && o_r == $past(i_rsp))
    else $error("network response not passed to R on the next cycle");

endmodule

bind tnoc_axi_local_port tnoc_axi_local_port_assert u_assert (
  .clk(clk), .i_rst_n(i_rst_n),
  .i_write_valid(write_valid), .i_write_flit(write_flit), .i_write_ready(write_ready),
  .i_read_valid(read_valid), .i_read_flit(read_flit), .i_read_ready(read_ready),
  .o_b_valid(o_b_valid), .i_b_ready(i_b_ready), .o_r_valid(o_r_valid), .o_r(o_r),
  .i_r_ready(i_r_ready), .i_rsp_valid(i_rsp_valid), .i_rsp(i_rsp), .o_rsp_ready(o_rsp_ready)
);

// ==== dv/tnoc_axi_local_port_tb.sv ====
`timescale 1ns/1ns

`include "tnoc_cfg.svh"

module tnoc_axi_local_port_tb
  import tnoc_pkg::*;
();

  localparam int TIMEOUT = 2000;

  logic clk = 1'b0;
  logic i_rst_n, i_aw_valid, i_w_valid, i_b_ready, i_ar_valid, i_r_ready, i_rsp_valid;
  tnoc_axil_a_t i_aw, i_ar;
  tnoc_axil_w_t i_w;
  tnoc_rsp_t i_rsp;
  tnoc_vc_t i_write_vc, i_read_vc;
  logic [`TNOC_VCS-1:0] i_flit_vc_ready, ready_force;
  logic o_aw_ready, o_w_ready, o_b_valid, o_ar_ready, o_r_valid, o_flit_valid, o_rsp_ready;
  tnoc_resp_t o_b_resp;
  tnoc_axil_r_t o_r;
  tnoc_flit_t o_flit, exp_f, held_flit;

  tnoc_flit_t exp_write_q[$];
  tnoc_flit_t exp_read_q[$];
  tnoc_addr_t rsp_addr_q[$];
  tnoc_resp_t exp_resp_q[$];
  int value_errors = 0;
  int other_errors = 0;
  int ready_mode = 0;
  int rsp_delay = 0;
  int flits_taken = 0;
  bit bp_on = 0;
  tnoc_kind_t last_kind;
  tnoc_addr_t rsp_a;
  tnoc_resp_t rsp_code;

  tnoc_axi_local_port dut (.*);

  always #50 clk = ~clk;

  function automatic tnoc_flit_t expected_flit(tnoc_kind_t kind, tnoc_vc_t vc, tnoc_addr_t addr,
                                               tnoc_data_t data, tnoc_strb_t strb);
    tnoc_flit_t f;
    f.kind = kind;
    f.vc   = vc;
    f.addr = addr;
    f.data = data;
    f.strb = strb;
    return f;
  endfunction

  function automatic tnoc_data_t expected_read_data(tnoc_addr_t addr);
    return {addr[7:0], addr[15:8] ^ 8'h3c, ~addr};
  endfunction

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // network model
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(posedge clk) begin
    case (ready_mode)
      0: i_flit_vc_ready <= '1;
      1: i_flit_vc_ready <= $urandom_range(0, (1 << `TNOC_VCS) - 1);
      default: i_flit_vc_ready <= ready_force;
    endcase
  end

  // compares every taken flit and checks the round-robin turn under contention.
  always @(posedge clk) begin
    if (i_rst_n && o_flit_valid && i_flit_vc_ready[o_flit.vc]) begin
      if (flits_taken > 0 && o_flit.kind == last_kind && dut.write_valid && dut.read_valid &&
          i_flit_vc_ready[i_write_vc] && i_flit_vc_ready[i_read_vc]) begin
        $display("round-robin gave the same source two turns in a row");
        other_errors++;
      end
      if (o_flit.kind == TNOC_KIND_WRITE && exp_write_q.size() == 0 ||
          o_flit.kind == TNOC_KIND_READ && exp_read_q.size() == 0) begin
        $display("a flit was taken that no transaction expected");
        other_errors++;
      end else begin
        exp_f = (o_flit.kind == TNOC_KIND_WRITE) ? exp_write_q.pop_front() :
                                                   exp_read_q.pop_front();
        if (o_flit !== exp_f) begin
          $display("FAILED o_flit: got %h expected %h", o_flit, exp_f);
          value_errors++;
        end
        if (o_flit.kind == TNOC_KIND_READ) begin
          rsp_addr_q.push_back(o_flit.addr);
        end
      end
      last_kind = o_flit.kind;
      flits_taken++;
    end
  end

  always @(posedge clk) begin
    if (!i_rst_n) begin
      i_rsp_valid <= 1'b0;
      rsp_delay   <= 0;
    end else if (i_rsp_valid) begin
      if (o_rsp_ready) begin
        i_rsp_valid <= 1'b0;
      end
    end else if (rsp_addr_q.size() > 0) begin
      if (rsp_delay == 0) begin
        rsp_a    = rsp_addr_q.pop_front();
        rsp_code = $urandom_range(0, 3);
        exp_resp_q.push_back(rsp_code);
        i_rsp       <= '{data: expected_read_data(rsp_a), resp: rsp_code};
        i_rsp_valid <= 1'b1;
        rsp_delay   <= $urandom_range(0, 6);
      end else begin
        rsp_delay <= rsp_delay - 1;
      end
    end
  end

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // AXI4-Lite master
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h expected %h", name, got, exp);
      value_errors++;
    end
  endtask

  task automatic send_aw(input tnoc_addr_t addr);
    int t;
    t = 0;
    i_aw_valid <= 1'b1;
    i_aw       <= '{addr: addr, prot: 3'b000};
    do begin
      @(posedge clk);
      t++;
    end while (!o_aw_ready && t < TIMEOUT);
    i_aw_valid <= 1'b0;
    if (t >= TIMEOUT) begin
      $display("timeout waiting for the AW handshake");
      other_errors++;
    end
  endtask

  task automatic send_w(input tnoc_data_t data, input tnoc_strb_t strb);
    int t;
    t = 0;
    i_w_valid <= 1'b1;
    i_w       <= '{data: data, strb: strb};
    do begin
      @(posedge clk);
      t++;
    end while (!o_w_ready && t < TIMEOUT);
    i_w_valid <= 1'b0;
    if (t >= TIMEOUT) begin
      $display("timeout waiting for the W handshake");
      other_errors++;
    end
  endtask

  task automatic send_ar(input tnoc_addr_t addr);
    int t;
    t = 0;
    i_ar_valid <= 1'b1;
    i_ar       <= '{addr: addr, prot: 3'b000};
    do begin
      @(posedge clk);
      t++;
    end while (!o_ar_ready && t < TIMEOUT);
    i_ar_valid <= 1'b0;
    if (t >= TIMEOUT) begin
      $display("timeout waiting for the AR handshake");
      other_errors++;
    end
  endtask

  task automatic collect_b();
    int t;
    t = 0;
    while (!(o_b_valid && i_b_ready) && t < TIMEOUT) begin
      i_b_ready <= bp_on ? $urandom_range(0, 1) : 1'b1;
      @(posedge clk);
      t++;
    end
    i_b_ready <= 1'b0;
    if (t >= TIMEOUT) begin
      $display("timeout waiting for the B response");
      other_errors++;
    end else begin
      if (exp_write_q.size() != 0) begin
        $display("a B response arrived before its write flit was taken");
        other_errors++;
      end
      if (o_b_resp !== TNOC_RESP_OKAY) begin
        $display("FAILED o_b_resp: got %h expected %h", o_b_resp, TNOC_RESP_OKAY);
        value_errors++;
      end
    end
  endtask

  task automatic collect_r(input tnoc_addr_t addr);
    int t;
    tnoc_resp_t resp;
    t = 0;
    while (!(o_r_valid && i_r_ready) && t < TIMEOUT) begin
      i_r_ready <= bp_on ? $urandom_range(0, 1) : 1'b1;
      @(posedge clk);
      t++;
    end
    i_r_ready <= 1'b0;
    if (t >= TIMEOUT) begin
      $display("timeout waiting for the R response");
      other_errors++;
    end else if (exp_resp_q.size() == 0) begin
      $display("an R response arrived with no network response behind it");
      other_errors++;
    end else begin
      resp = exp_resp_q.pop_front();
      if (o_r.data !== expected_read_data(addr)) begin
        $display("FAILED o_r.data: got %h expected %h", o_r.data, expected_read_data(addr));
        value_errors++;
      end
      if (o_r.resp !== resp) begin
        $display("FAILED o_r.resp: got %h expected %h", o_r.resp, resp);
        value_errors++;
      end
    end
  endtask

  task automatic do_write(input tnoc_vc_t vc, input tnoc_addr_t addr, input tnoc_data_t data,
                          input tnoc_strb_t strb);
    int order;
    order = $urandom_range(0, 2);
    @(posedge clk);
    i_write_vc <= vc;
    exp_write_q.push_back(expected_flit(TNOC_KIND_WRITE, vc, addr, data, strb));
    if (order == 0) begin
      send_aw(addr);
      send_w(data, strb);
    end else if (order == 1) begin
      send_w(data, strb);
      send_aw(addr);
    end else begin
      fork
        send_aw(addr);
        send_w(data, strb);
      join
    end
    collect_b();
  endtask

  task automatic do_read(input tnoc_vc_t vc, input tnoc_addr_t addr);
    @(posedge clk);
    i_read_vc <= vc;
    exp_read_q.push_back(expected_flit(TNOC_KIND_READ, vc, addr, '0, '0));
    send_ar(addr);
    collect_r(addr);
  endtask

  task automatic wait_write_offered();
    int t;
    t = 0;
    while (!dut.write_valid && t < TIMEOUT) begin
      @(posedge clk);
      t++;
    end
    if (t >= TIMEOUT) begin
      $display("timeout waiting for the write packetizer to offer its flit");
      other_errors++;
    end
  endtask

  task automatic random_writes(input int n);
    repeat (n) begin
      do_write($urandom_range(0, `TNOC_VCS - 1), $urandom_range(0, 16'hffff), $urandom,
               $urandom_range(0, 15));
    end
  endtask

  task automatic random_reads(input int n);
    repeat (n) begin
      do_read($urandom_range(0, `TNOC_VCS - 1), $urandom_range(0, 16'hffff));
    end
  endtask

  initial begin
    void'($urandom(32'h056623ce));
    i_rst_n = 1'b0;
    i_aw_valid = 1'b0;
    i_w_valid = 1'b0;
    i_ar_valid = 1'b0;
    i_b_ready = 1'b0;
    i_r_ready = 1'b0;
    i_rsp_valid = 1'b0;
    i_aw = '0;
    i_w = '0;
    i_ar = '0;
    i_rsp = '0;
    i_write_vc = '0;
    i_read_vc = '0;
    i_flit_vc_ready = '1;
    ready_force = '1;
    repeat (10) @(posedge clk);

    // values that reset leaves on the outside ports.
    check_bit("o_aw_ready", o_aw_ready, 1'b1);
    check_bit("o_w_ready", o_w_ready, 1'b1);
    check_bit("o_ar_ready", o_ar_ready, 1'b1);
    check_bit("o_flit_valid", o_flit_valid, 1'b0);
    check_bit("o_b_valid", o_b_valid, 1'b0);
    check_bit("o_r_valid", o_r_valid, 1'b0);
    check_bit("o_rsp_ready", o_rsp_ready, 1'b0);
    i_rst_n <= 1'b1;

    do_write(1, 16'h1234, 32'hcafe_f00d, 4'hb);
    do_read(0, 16'h0abc);

    // both sources on one VC that never stalls.
    fork
      repeat (20) do_write(1, $urandom_range(0, 16'hffff), $urandom, 4'hf);
      repeat (20) do_read(1, $urandom_range(0, 16'hffff));
    join

    // the write VC is stalled while the read VC stays open.
    ready_mode  = 2;
    ready_force = 2'b10;
    fork
      do_write(0, 16'h00f0, 32'h1111_2222, 4'h3);
      begin
        wait_write_offered();
        held_flit = dut.write_flit;
        do_read(1, 16'h0f00);
        if (!dut.write_valid || dut.write_flit !== held_flit || exp_write_q.size() != 1) begin
          $display("the stalled write flit was not held while the read passed");
          other_errors++;
        end
        ready_force = 2'b11;
      end
    join

    ready_mode = 1;
    bp_on      = 1;
    fork
      random_writes(100);
      random_reads(100);
    join

    if (exp_write_q.size() != 0 || exp_read_q.size() != 0) begin
      $display("%0d expected flits never left the DUT", exp_write_q.size() + exp_read_q.size());
      other_errors++;
    end
    $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+hdl
hdl/tnoc_pkg.sv
hdl/tnoc_axi_write_packetizer.sv
hdl/tnoc_axi_read_packetizer.sv
hdl/tnoc_axi_write_read_mux.sv
hdl/tnoc_axi_local_port.sv
dv/tnoc_axi_local_port_assert.sv
dv/tnoc_axi_local_port_tb.sv
